//--- verilog.f
router_pkg.sv
pkt_byte_counter.sv
hdr_parse_fsm.sv
beat_delay_line.sv
decision_fifo.sv
egress_steer.sv
pkt_router_top.sv
pkt_router_checker.sv
tb_pkt_router.sv

//--- run_sim.sh
#!/bin/sh
# build and run the packet router testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_pkt_router \
    --Mdir obj_dir -o sim_router
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_router)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

//--- tb_pkt_router.sv
// router testbench
// drives a table of packets into the router, checker grades the egress ports
`timescale 1ns/10ps

module tb_pkt_router import router_pkg::*; ();

    localparam int          MAX_PKT_BYTES = 100;
    localparam logic [47:0] LOCAL_MAC     = 48'hAA_BB_CC_DD_EE_FF;
    localparam logic [47:0] BCAST_MAC     = 48'hFF_FF_FF_FF_FF_FF;
    localparam logic [47:0] OTHER_MAC     = 48'h00_11_22_33_44_55;
    localparam logic [47:0] SRC_MAC       = 48'h02_00_00_00_00_01;
    localparam int          LATENCY       = 15;
    localparam int          NUM_ROWS      = 16;
    localparam int          DRAIN_TIMEOUT = 400;

    logic       core_clk_ifc = 1'b0;
    logic       rst_n;
    logic       ing_valid;
    beat_t      ing_beat;
    port_mask_t egr_valid;
    beat_t      egr_beat;
    int         exp_pkt;
    int         exp_pos;
    int         exp_len;
    port_mask_t exp_mask;
    int         pass_count;
    int         fail_count;
    int         misc_count;

    // stimulus table, one packet per row
    logic [47:0] row_dmac  [NUM_ROWS];
    int          row_len   [NUM_ROWS];
    logic [7:0]  row_first [NUM_ROWS];
    port_mask_t  row_mask  [NUM_ROWS];
    // no idle gap after this row
    logic        row_tight [NUM_ROWS];
    int          n_rows = 0;
    int          seed   = 58299;
    logic [7:0]  pkt_bytes [256];

    always #20 core_clk_ifc = ~core_clk_ifc;

    pkt_router_top i_dut (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .ing_valid    (ing_valid),
        .ing_beat     (ing_beat),
        .egr_valid    (egr_valid),
        .egr_beat     (egr_beat)
    );

    pkt_router_checker #(
        .MAX_PKT_BYTES (MAX_PKT_BYTES),
        .HDR_BYTES     (14),
        .LATENCY       (LATENCY)
    ) i_chk (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .ing_valid    (ing_valid),
        .ing_beat     (ing_beat),
        .egr_valid    (egr_valid),
        .egr_beat     (egr_beat),
        .exp_pkt      (exp_pkt),
        .exp_pos      (exp_pos),
        .exp_len      (exp_len),
        .exp_mask     (exp_mask),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .misc_count   (misc_count)
    );

    task automatic add_row(input logic [47:0] dmac, input int len, input logic [7:0] first,
                           input port_mask_t mask, input logic tight);
        row_dmac[n_rows]  = dmac;
        row_len[n_rows]   = len;
        row_first[n_rows] = first;
        row_mask[n_rows]  = mask;
        row_tight[n_rows] = tight;
        n_rows++;
    endtask

    //////////////////////////////////////////////////
    // dmac, length, first payload byte, expected ports
    //////////////////////////////////////////////////

    task automatic fill_table();
        add_row(LOCAL_MAC,  64, 8'h11, 2'b01, 1'b0);
        add_row(BCAST_MAC,  60, 8'h22, 2'b11, 1'b0);
        add_row(OTHER_MAC,  72, 8'h33, 2'b10, 1'b0);
        // header only
        add_row(LOCAL_MAC,  14, 8'h00, 2'b01, 1'b0);
        // runts back to back
        add_row(LOCAL_MAC,  13, 8'h00, 2'b00, 1'b1);
        add_row(BCAST_MAC,   1, 8'h00, 2'b00, 1'b1);
        add_row(OTHER_MAC,   7, 8'h00, 2'b00, 1'b0);
        // truncated, then a packet right behind it
        add_row(OTHER_MAC, 130, 8'h44, 2'b10, 1'b1);
        add_row(LOCAL_MAC,  40, 8'h55, 2'b01, 1'b0);
        add_row(BCAST_MAC, 100, 8'h66, 2'b11, 1'b0);
        add_row(LOCAL_MAC,   5, 8'h00, 2'b00, 1'b1);
        add_row(OTHER_MAC,   2, 8'h00, 2'b00, 1'b1);
        add_row(BCAST_MAC,  13, 8'h00, 2'b00, 1'b1);
        // one bit off the local mac
        add_row(48'hAA_BB_CC_DD_EE_FE, 15, 8'h77, 2'b10, 1'b0);
        add_row(BCAST_MAC, 130, 8'h88, 2'b11, 1'b0);
        add_row(LOCAL_MAC,  20, 8'h99, 2'b01, 1'b0);
    endtask

    // dmac, smac, ethertype, then payload
    task automatic build_bytes(input int row);
        logic [31:0] rnd;
        for (int i = 0; i < row_len[row]; i++) begin
            if (i < 6) pkt_bytes[i] = row_dmac[row][47 - 8*i -: 8];
            else if (i < 12) pkt_bytes[i] = SRC_MAC[95 - 8*i -: 8];
            else if (i == 12) pkt_bytes[i] = 8'h08;
            else if (i == 13) pkt_bytes[i] = 8'h00;
            else if (i == 14) pkt_bytes[i] = row_first[row];
            else begin
                rnd          = $random(seed);
                pkt_bytes[i] = rnd[7:0];
            end
        end
    endtask

    // one byte per cycle, 1 ns after the rising edge
    task automatic drive_packet(input int row);
        logic [31:0] rnd;
        int          gap;
        build_bytes(row);
        for (int i = 0; i < row_len[row]; i++) begin
            ing_valid     = 1'b1;
            ing_beat.data = pkt_bytes[i];
            ing_beat.last = (i == row_len[row] - 1);
            exp_pkt       = row;
            exp_pos       = i;
            exp_len       = row_len[row];
            exp_mask      = row_mask[row];
            @(posedge core_clk_ifc);
            #1;
        end
        ing_valid = 1'b0;
        ing_beat  = '0;
        rnd       = $random(seed);
        gap       = row_tight[row] ? 0 : int'(rnd[1:0]);
        repeat (gap) begin
            @(posedge core_clk_ifc);
            #1;
        end
    endtask

    initial begin : main
        int   waited;
        logic timed_out;
        rst_n     = 1'b0;
        ing_valid = 1'b0;
        ing_beat  = '0;
        exp_pkt   = 0;
        exp_pos   = 0;
        exp_len   = 0;
        exp_mask  = '0;
        fill_table();
        repeat (5) @(posedge core_clk_ifc);
        #1 rst_n = 1'b1;
        @(posedge core_clk_ifc);
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_packet(r);
        end
        // every row reports once its ingress last is graded
        waited = 0;
        while ((pass_count + fail_count) < NUM_ROWS && waited < DRAIN_TIMEOUT) begin
            @(posedge core_clk_ifc);
            waited++;
        end
        timed_out = ((pass_count + fail_count) < NUM_ROWS);
        if (timed_out) begin
            $display("timeout: only %0d of %0d packets graded", pass_count + fail_count,
                     NUM_ROWS);
        end
        // quiet tail, any late egress beat counts as stray
        repeat (LATENCY + 5) @(posedge core_clk_ifc);
        $display("summary: %0d packets passed, %0d failed, %0d other errors",
                 pass_count, fail_count, misc_count);
        if (!timed_out && fail_count == 0 && misc_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- pkt_router_checker.sv
// router checker
// predicts the egress stream from the ingress beats and grades every egress cycle
`timescale 1ns/10ps

module pkt_router_checker import router_pkg::*; #(
    parameter int MAX_PKT_BYTES = 100,
    parameter int HDR_BYTES     = 14,
    parameter int LATENCY       = 15
) (
    input  logic       core_clk_ifc,
    input  logic       rst_n,
    input  logic       ing_valid,
    input  beat_t      ing_beat,
    input  port_mask_t egr_valid,
    input  beat_t      egr_beat,
    // packet context of the beat now on ingress
    input  int         exp_pkt,
    input  int         exp_pos,
    input  int         exp_len,
    input  port_mask_t exp_mask,
    output int         pass_count,
    output int         fail_count,
    output int         misc_count
);

    // one ingress beat and what egress must show for it
    typedef struct packed {
        int         due;
        int         pkt;
        int         pos;
        int         kept_len;
        logic       keep;
        logic       last;
        logic       pkt_end;
        port_mask_t mask;
        logic [7:0] data;
    } beat_exp_t;

    beat_exp_t timeline_q [$];
    int        cycle     = 0;
    int        pkt_errs  = 0;
    int        fwd_bytes = 0;
    int        pass_n    = 0;
    int        fail_n    = 0;
    int        misc_n    = 0;

    assign pass_count = pass_n;
    assign fail_count = fail_n;
    assign misc_count = misc_n;

    // grade the egress cycle that belongs to one ingress beat
    task automatic check_due(input beat_exp_t e);
        port_mask_t want;
        want = e.keep ? e.mask : '0;
        if (egr_valid !== want) begin
            $display("error: pkt %0d byte %0d egr_valid exp 0x%h got 0x%h",
                     e.pkt, e.pos, want, egr_valid);
            pkt_errs++;
        end else if (want != '0) begin
            fwd_bytes++;
            if (egr_beat.data !== e.data) begin
                $display("error: pkt %0d byte %0d egr_beat.data exp 0x%h got 0x%h",
                         e.pkt, e.pos, e.data, egr_beat.data);
                pkt_errs++;
            end
            if (egr_beat.last !== e.last) begin
                $display("error: pkt %0d byte %0d egr_beat.last exp 0x%h got 0x%h",
                         e.pkt, e.pos, e.last, egr_beat.last);
                pkt_errs++;
            end
        end
        // packet closes with its ingress last, dropped tail included
        if (e.pkt_end) begin
            if (pkt_errs == 0) pass_n++;
            else fail_n++;
            $display("pkt %0d: %s, %0d of %0d bytes forwarded", e.pkt,
                     (pkt_errs == 0) ? "pass" : "fail", fwd_bytes, e.kept_len);
            pkt_errs  = 0;
            fwd_bytes = 0;
        end
    endtask

    //////////////////////////////////////////////////
    // monitor, sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge core_clk_ifc) begin : monitor
        beat_exp_t e;
        int        kept;
        cycle++;
        if (ing_valid === 1'b1) begin
            // runts keep nothing, long packets keep the first MAX_PKT_BYTES
            kept = (exp_len < HDR_BYTES) ? 0 :
                   ((exp_len > MAX_PKT_BYTES) ? MAX_PKT_BYTES : exp_len);
            e.due      = cycle + LATENCY;
            e.pkt      = exp_pkt;
            e.pos      = exp_pos;
            e.kept_len = kept;
            e.keep     = (exp_pos < kept);
            e.last     = (exp_pos == kept - 1);
            e.pkt_end  = (exp_pos == exp_len - 1);
            e.mask     = exp_mask;
            e.data     = ing_beat.data;
            timeline_q.push_back(e);
        end
        // fixed latency, so only the oldest entry can be due
        if (timeline_q.size() != 0 && timeline_q[0].due == cycle) begin
            check_due(timeline_q.pop_front());
        end else if (egr_valid !== '0) begin
            $display("error: egr_valid 0x%h with no expected beat (rst_n %0b)",
                     egr_valid, rst_n);
            misc_n++;
        end
    end

endmodule

//--- pkt_router_top.sv
// packet router top
// one byte-wide ingress stream steered by destination mac to two egress ports
`timescale 1ns/10ps

module pkt_router_top import router_pkg::*; #(
    parameter int          MAX_PKT_BYTES  = 100,
    parameter logic [47:0] LOCAL_MAC      = 48'hAA_BB_CC_DD_EE_FF,
    parameter int          DEC_FIFO_DEPTH = 16
) (
    input  logic       core_clk_ifc,
    input  logic       rst_n,
    input  logic       ing_valid,
    input  beat_t      ing_beat,
    output port_mask_t egr_valid,
    output beat_t      egr_beat
);

    //////////////////////////////////////////////////
    // ingress side
    //////////////////////////////////////////////////

    byte_idx_t     byte_index;
    logic          at_max;
    logic          pass_valid;
    beat_t         pass_beat;
    logic          dec_push;
    fwd_decision_t fsm_dec;
    // egress side
    logic          dly_valid;
    beat_t         dly_beat;
    logic          dec_pop;
    logic          dec_empty;
    fwd_decision_t fifo_dec;

    pkt_byte_counter #(
        .MAX_PKT_BYTES (MAX_PKT_BYTES)
    ) i_counter (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .ing_valid    (ing_valid),
        .ing_beat     (ing_beat),
        .byte_index   (byte_index),
        .at_max       (at_max)
    );

    hdr_parse_fsm #(
        .LOCAL_MAC (LOCAL_MAC)
    ) i_parser (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .ing_valid    (ing_valid),
        .ing_beat     (ing_beat),
        .byte_index   (byte_index),
        .at_max       (at_max),
        .pass_valid   (pass_valid),
        .pass_beat    (pass_beat),
        .dec_push     (dec_push),
        .dec_out      (fsm_dec)
    );

    // header length of delay, decision lands in the fifo in time
    beat_delay_line i_delay (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (pass_valid),
        .in_beat      (pass_beat),
        .out_valid    (dly_valid),
        .out_beat     (dly_beat)
    );

    decision_fifo #(
        .DEPTH (DEC_FIFO_DEPTH)
    ) i_dec_fifo (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .push         (dec_push),
        .din          (fsm_dec),
        .pop          (dec_pop),
        .dout         (fifo_dec),
        .empty        (dec_empty)
    );

    egress_steer i_steer (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .dly_valid    (dly_valid),
        .dly_beat     (dly_beat),
        .dec_empty    (dec_empty),
        .dec_in       (fifo_dec),
        .dec_pop      (dec_pop),
        .egr_valid    (egr_valid),
        .egr_beat     (egr_beat)
    );

endmodule

//--- egress_steer.sv
// egress steering
// applies one popped decision per packet and registers both egress ports
`timescale 1ns/10ps

module egress_steer import router_pkg::*; (
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  logic          dly_valid,
    input  beat_t         dly_beat,
    input  logic          dec_empty,
    input  fwd_decision_t dec_in,
    output logic          dec_pop,
    output port_mask_t    egr_valid,
    output beat_t         egr_beat
);

    logic       pkt_open;
    logic       first_beat;
    port_mask_t cur_mask;
    port_mask_t mask_sel;

    // packet start seen at the delay line output
    assign first_beat = dly_valid && !pkt_open;
    assign dec_pop    = first_beat && !dec_empty;

    // fresh mask on the first beat, held mask afterwards
    always_comb begin
        mask_sel = cur_mask;
        if (first_beat) begin
            mask_sel = dec_empty ? '0 : dec_in.mask;
        end
    end

    //////////////////////////////////////////////////
    // control and output registers
    //////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            pkt_open  <= 1'b0;
            cur_mask  <= '0;
            egr_valid <= '0;
        end else begin
            if (dly_valid) begin
                // close on last, reopen on the next beat
                pkt_open <= !dly_beat.last;
                cur_mask <= mask_sel;
            end
            egr_valid <= dly_valid ? mask_sel : '0;
        end
    end

    // shared data for both ports
    always_ff @(posedge core_clk_ifc) begin
        egr_beat <= dly_beat;
    end

    // parser must have decided before the packet leaves the delay line
    a_dec_ready: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        first_beat |-> !dec_empty) else $error("no decision for outgoing packet");

endmodule

//--- decision_fifo.sv
// decision fifo
// circular buffer of forwarding decisions, show-ahead read
`timescale 1ns/10ps

module decision_fifo import router_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  logic          push,
    input  fwd_decision_t din,
    input  logic          pop,
    output fwd_decision_t dout,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fwd_decision_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    // head visible the cycle after its write
    assign dout    = mem[rd_ptr];

    always_ff @(posedge core_clk_ifc) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    // pointers wrap at DEPTH, any depth allowed
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    a_no_overflow: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        push |-> !full) else $error("decision fifo overflow");
    a_no_underflow: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        pop |-> !empty) else $error("decision fifo underflow");

endmodule

//--- beat_delay_line.sv
// header delay line
// holds ingress beats for one header length so the decision is ready at egress
`timescale 1ns/10ps

module beat_delay_line import router_pkg::*; (
    input  logic  core_clk_ifc,
    input  logic  rst_n,
    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  out_valid,
    output beat_t out_beat
);

    logic [HEADER_BYTES-1:0] valid_q;
    beat_t                   beat_q [HEADER_BYTES];

    // valid shifts every cycle, bubbles included
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[HEADER_BYTES-2:0], in_valid};
        end
    end

    // payload stages
    always_ff @(posedge core_clk_ifc) begin
        beat_q[0] <= in_beat;
        for (int i = 1; i < HEADER_BYTES; i++) begin
            beat_q[i] <= beat_q[i-1];
        end
    end

    assign out_valid = valid_q[HEADER_BYTES-1];
    assign out_beat  = beat_q[HEADER_BYTES-1];

endmodule

//--- hdr_parse_fsm.sv
// ingress header parser
// captures the dmac, decides the egress ports and truncates long packets
`timescale 1ns/10ps

module hdr_parse_fsm import router_pkg::*; #(
    parameter logic [47:0] LOCAL_MAC = 48'hAA_BB_CC_DD_EE_FF
) (
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  logic          ing_valid,
    input  beat_t         ing_beat,
    input  byte_idx_t     byte_index,
    input  logic          at_max,
    output logic          pass_valid,
    output beat_t         pass_beat,
    output logic          dec_push,
    output fwd_decision_t dec_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload,
        st_discard
    } state_t;

    state_t      state;
    state_t      state_nxt;
    logic [47:0] dmac;
    logic        in_hdr;
    logic        hdr_done;

    assign in_hdr   = (state == st_idle) || (state == st_header);
    // byte 13 closes the header
    assign hdr_done = (byte_index == byte_idx_t'(HEADER_BYTES - 1));

    //////////////////////////////////////////////////
    // dmac capture, first byte ends up msb
    //////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (ing_valid && (byte_index < byte_idx_t'(DMAC_BYTES))) begin
            dmac <= {dmac[39:0], ing_beat.data};
        end
    end

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        if (ing_valid) begin
            case (state)
                st_idle: begin
                    // single byte packet stays idle
                    if (!ing_beat.last) state_nxt = st_header;
                end
                st_header: begin
                    if (ing_beat.last) state_nxt = st_idle;
                    else if (hdr_done) state_nxt = st_payload;
                end
                st_payload: begin
                    if (ing_beat.last) state_nxt = st_idle;
                    else if (at_max) state_nxt = st_discard;
                end
                default: begin
                    // drop the tail until the sender closes the packet
                    if (ing_beat.last) state_nxt = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // decision on byte 13, or zero mask when a runt closes early
    always_comb begin
        dec_push     = ing_valid && in_hdr && (hdr_done || ing_beat.last);
        dec_out.mask = '0;
        if (hdr_done) begin
            if (dmac == BROADCAST_MAC) dec_out.mask = '1;
            else if (dmac == LOCAL_MAC) dec_out.mask = port_mask_t'(2'b01);
            else dec_out.mask = port_mask_t'(2'b10);
        end
    end

    // tail bytes withheld, last forced on the final kept byte
    assign pass_valid     = ing_valid && (state != st_discard);
    assign pass_beat.data = ing_beat.data;
    assign pass_beat.last = ing_beat.last || at_max;

    // counter and fsm must agree on packet boundaries
    a_idle_at_start: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        (state == st_idle) |-> (byte_index == '0))
        else $error("parser idle with byte index %0d", byte_index);

endmodule

//--- pkt_byte_counter.sv
// ingress byte counter
// tracks the byte position in the current packet and flags the last kept byte
`timescale 1ns/10ps

module pkt_byte_counter import router_pkg::*; #(
    parameter int MAX_PKT_BYTES = 100
) (
    input  logic      core_clk_ifc,
    input  logic      rst_n,
    input  logic      ing_valid,
    input  beat_t     ing_beat,
    output byte_idx_t byte_index,
    output logic      at_max
);

    // index of the beat currently on the ingress bus
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            byte_index <= '0;
        end else if (ing_valid) begin
            if (ing_beat.last) begin
                // next beat opens a new packet
                byte_index <= '0;
            end else if (byte_index < byte_idx_t'(MAX_PKT_BYTES)) begin
                byte_index <= byte_index + 1'b1;
            end
            // saturate past the limit, the rest gets discarded anyway
        end
    end

    // last byte that survives truncation
    assign at_max = (byte_index == byte_idx_t'(MAX_PKT_BYTES - 1));

endmodule

//--- router_pkg.sv
// router package
// stream beat, port mask and decision types plus ethernet header constants
package router_pkg;

    //////////////////////////////////////////////////
    // header constants
    //////////////////////////////////////////////////

    // dmac + smac + ethertype
    localparam int HEADER_BYTES = 14;
    // destination mac sits in bytes 0..5
    localparam int DMAC_BYTES = 6;
    localparam logic [47:0] BROADCAST_MAC = 48'hFF_FF_FF_FF_FF_FF;
    localparam int NUM_EGR_PORTS = 2;

    //////////////////////////////////////////////////
    // stream and decision types
    //////////////////////////////////////////////////

    // one byte of the stream with its end of packet flag
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } beat_t;

    // one enable per egress port, all zero drops the packet
    typedef logic [NUM_EGR_PORTS-1:0] port_mask_t;

    // forwarding result of one packet
    typedef struct packed {
        port_mask_t mask;
    } fwd_decision_t;

    // byte position inside a packet, wide enough for jumbo limits
    typedef logic [15:0] byte_idx_t;

endpackage
